//--- common/shifter_defines.svh
`ifndef SHIFTER_DEFINES_SVH
`define SHIFTER_DEFINES_SVH

// Width of the switch word and of the shift result
`define SHIFT_DATA_W 16

// clk_demo cycles between scan/debounce ticks
// Small for simulation, set large on the board
`define SHIFT_TICK_DIV 8

// Agreeing tick samples before a button level is accepted
`define SHIFT_DEBOUNCE_TICKS 4

`endif

//--- common/shift_pkg.sv
`default_nettype none

package shift_pkg;

    // Shifter operation, decoded from rotate and direction
    typedef enum logic [1:0] {
        OP_SLL = 2'b00,
        OP_SRL = 2'b01,
        OP_ROL = 2'b10,
        OP_ROR = 2'b11
    } shift_op_e;

    // Four-bit shift amount, high pair from the counter
    typedef logic [3:0] shamt_t;

endpackage

`default_nettype wire

//--- common/display_pkg.sv
`default_nettype none

package display_pkg;

    // Segments a..g on bits 0..6, active low
    typedef logic [6:0] seg_t;

    // Index of one of the eight digits
    typedef logic [2:0] digit_sel_t;

    // All segments dark
    localparam seg_t SEG_BLANK = 7'b111_1111;

    // Scan positions, digit 0 is rightmost
    typedef enum logic [2:0] {
        SCAN_D0, SCAN_D1, SCAN_D2, SCAN_D3,
        SCAN_D4, SCAN_D5, SCAN_D6, SCAN_D7
    } scan_state_e;

endpackage

`default_nettype wire

//--- common/shift_ctrl_if.sv
`default_nettype none
`include "shifter_defines.svh"

// Operands and result between shift control and the shifter
interface shift_ctrl_if;
    import shift_pkg::*;

    logic [`SHIFT_DATA_W-1:0] data;
    shamt_t                   amount;
    shift_op_e                op;
    logic [`SHIFT_DATA_W-1:0] result;

    modport ctrl (
        output data,
        output amount,
        output op,
        input  result
    );

    modport shifter (
        input  data,
        input  amount,
        input  op,
        output result
    );

endinterface

`default_nettype wire

//--- hdl/tick_gen.sv
`default_nettype none
`include "shifter_defines.svh"

module tick_gen (
    input  logic clk_demo,
    input  logic reset,
    output logic tick
);

    localparam int CNT_W = $clog2(`SHIFT_TICK_DIV);

    logic [CNT_W-1:0] div_cnt;

    // One-cycle enable every SHIFT_TICK_DIV cycles
    always_ff @(posedge clk_demo) begin
        if (reset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == CNT_W'(`SHIFT_TICK_DIV - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/button_conditioner.sv
`default_nettype none
`include "shifter_defines.svh"

module button_conditioner (
    input  logic clk_demo,
    input  logic reset,
    input  logic tick,
    input  logic btn_raw,
    output logic level_toggle,
    output logic press
);

    localparam int CNT_W = $clog2(`SHIFT_DEBOUNCE_TICKS + 1);

    logic [1:0]       sync_q;
    logic             accepted;
    logic [CNT_W-1:0] stable_cnt;
    logic             differs;
    logic             accept_now;

    // Raw pin into the clk_demo domain
    always_ff @(posedge clk_demo) begin
        if (reset) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], btn_raw};
        end
    end

    assign differs    = sync_q[1] != accepted;
    assign accept_now = tick && differs
                        && (stable_cnt == CNT_W'(`SHIFT_DEBOUNCE_TICKS - 1));

    ////////////////////////////////////////
    // Debounce and edge handling
    ////////////////////////////////////////
    always_ff @(posedge clk_demo) begin
        if (reset) begin
            accepted     <= 1'b0;
            stable_cnt   <= '0;
            level_toggle <= 1'b0;
            press        <= 1'b0;
        end else begin
            press <= 1'b0;
            if (tick) begin
                if (!differs) begin
                    // Glitch or no change, start over
                    stable_cnt <= '0;
                end else if (accept_now) begin
                    accepted   <= sync_q[1];
                    stable_cnt <= '0;
                    if (sync_q[1]) begin
                        level_toggle <= ~level_toggle;
                        press        <= 1'b1;
                    end
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/shift_control.sv
`default_nettype none
`include "shifter_defines.svh"

module shift_control (
    input  logic                     clk_demo,
    input  logic                     reset,
    input  logic [`SHIFT_DATA_W-1:0] sw,
    input  logic                     dir,
    input  logic                     rotate,
    input  logic [1:0]               amt_lo,
    input  logic                     advance,
    shift_ctrl_if.ctrl               ctrl,
    output logic [`SHIFT_DATA_W-1:0] result_out,
    output logic [7:0]               led
);
    import shift_pkg::*;

    logic [1:0] amt_hi;
    shamt_t     amount;
    shift_op_e  op_dec;

    // High pair of the amount, one step per press
    always_ff @(posedge clk_demo) begin
        if (reset) begin
            amt_hi <= 2'b00;
        end else if (advance) begin
            amt_hi <= amt_hi + 2'd1;
        end
    end

    assign amount = {amt_hi, amt_lo};

    // Direction 0 is left
    always_comb begin
        case ({rotate, dir})
            2'b00:   op_dec = OP_SLL;
            2'b01:   op_dec = OP_SRL;
            2'b10:   op_dec = OP_ROL;
            default: op_dec = OP_ROR;
        endcase
    end

    ////////////////////////////////////////
    // Registered controls and LED word
    ////////////////////////////////////////
    always_ff @(posedge clk_demo) begin
        if (reset) begin
            ctrl.amount <= '0;
            ctrl.op     <= OP_SLL;
            led         <= 8'h00;
        end else begin
            ctrl.amount <= amount;
            ctrl.op     <= op_dec;
            led         <= {amount, rotate, dir, 2'b00};
        end
    end

    // Switch word, plain payload
    always_ff @(posedge clk_demo) begin
        ctrl.data <= sw;
    end

    // Shifter output on to the display
    assign result_out = ctrl.result;

endmodule

`default_nettype wire

//--- shifter/barrel_shifter.sv
`default_nettype none
`include "shifter_defines.svh"

module barrel_shifter (
    shift_ctrl_if.shifter bus
);
    import shift_pkg::*;

    logic                     left;
    logic                     rot;
    logic [`SHIFT_DATA_W-1:0] stage [0:4];

    // One stage: fixed distance, fill with zeros or wrapped bits
    function automatic logic [`SHIFT_DATA_W-1:0] shift_stage(
        input logic [`SHIFT_DATA_W-1:0] d,
        input int unsigned              n,
        input logic                     to_left,
        input logic                     wrap
    );
        logic [`SHIFT_DATA_W-1:0] moved;
        logic [`SHIFT_DATA_W-1:0] spill;
        begin
            if (to_left) begin
                moved = d << n;
                spill = d >> (`SHIFT_DATA_W - n);
            end else begin
                moved = d >> n;
                spill = d << (`SHIFT_DATA_W - n);
            end
            shift_stage = wrap ? (moved | spill) : moved;
        end
    endfunction

    assign left = (bus.op == OP_SLL) || (bus.op == OP_ROL);
    assign rot  = (bus.op == OP_ROL) || (bus.op == OP_ROR);

    assign stage[0] = bus.data;

    ////////////////////////////////////////
    // Log stages of 1, 2, 4 and 8
    ////////////////////////////////////////
    genvar g;
    generate
        for (g = 0; g < 4; g++) begin : g_stage
            assign stage[g+1] = bus.amount[g]
                              ? shift_stage(stage[g], 1 << g, left, rot)
                              : stage[g];
        end
    endgenerate

    assign bus.result = stage[4];

endmodule

`default_nettype wire

//--- display/seg7_display.sv
`default_nettype none
`include "shifter_defines.svh"

module seg7_display (
    input  logic                     clk_demo,
    input  logic                     reset,
    input  logic                     tick,
    input  logic [`SHIFT_DATA_W-1:0] value,
    output logic [6:0]               seg,
    output logic [7:0]               an
);
    import display_pkg::*;

    scan_state_e state;
    digit_sel_t  idx;
    logic [3:0]  nibble;
    seg_t        pattern;

    // Hex digit to active-low segments, a on bit 0
    function automatic seg_t hex_to_seg(input logic [3:0] hex);
        begin
            case (hex)
                4'h0:    hex_to_seg = 7'b100_0000;
                4'h1:    hex_to_seg = 7'b111_1001;
                4'h2:    hex_to_seg = 7'b010_0100;
                4'h3:    hex_to_seg = 7'b011_0000;
                4'h4:    hex_to_seg = 7'b001_1001;
                4'h5:    hex_to_seg = 7'b001_0010;
                4'h6:    hex_to_seg = 7'b000_0010;
                4'h7:    hex_to_seg = 7'b111_1000;
                4'h8:    hex_to_seg = 7'b000_0000;
                4'h9:    hex_to_seg = 7'b001_0000;
                4'ha:    hex_to_seg = 7'b000_1000;
                4'hb:    hex_to_seg = 7'b000_0011;
                4'hc:    hex_to_seg = 7'b100_0110;
                4'hd:    hex_to_seg = 7'b010_0001;
                4'he:    hex_to_seg = 7'b000_0110;
                default: hex_to_seg = 7'b000_1110;
            endcase
        end
    endfunction

    assign idx    = digit_sel_t'(state);
    assign nibble = value[{idx[1:0], 2'b00} +: 4];

    // Upper four positions stay dark
    always_comb begin
        case (state)
            SCAN_D0,
            SCAN_D1,
            SCAN_D2,
            SCAN_D3: pattern = hex_to_seg(nibble);
            default: pattern = SEG_BLANK;
        endcase
    end

    ////////////////////////////////////////
    // Digit scan, one position per tick
    ////////////////////////////////////////
    always_ff @(posedge clk_demo) begin
        if (reset) begin
            state <= SCAN_D0;
            an    <= 8'hff;
            seg   <= SEG_BLANK;
        end else if (tick) begin
            // Anode and segments load together
            an    <= ~(8'b0000_0001 << idx);
            seg   <= pattern;
            state <= state.next();
        end
    end

endmodule

`default_nettype wire

//--- hdl/shifter_demo_top.sv
`default_nettype none
`include "shifter_defines.svh"

module shifter_demo_top (
    input  logic        clk_demo,
    input  logic        reset,
    input  logic [15:0] sw,
    input  logic [4:0]  btn,
    output logic [7:0]  led,
    output logic [6:0]  seg,
    output logic [7:0]  an
);

    logic                     tick;
    logic                     dir;
    logic                     rotate;
    logic [1:0]               amt_lo;
    logic                     advance;
    logic [`SHIFT_DATA_W-1:0] result;

    shift_ctrl_if u_shift_ctrl_if ();

    tick_gen u_tick_gen (
        .clk_demo (clk_demo),
        .reset    (reset),
        .tick     (tick)
    );

    ////////////////////////////////////////
    // Button conditioning
    ////////////////////////////////////////
    // Toggles for direction, rotate and amount low bits
    button_conditioner u_btn_dir (
        .clk_demo     (clk_demo),
        .reset        (reset),
        .tick         (tick),
        .btn_raw      (btn[0]),
        .level_toggle (dir),
        .press        ()
    );

    button_conditioner u_btn_rot (
        .clk_demo     (clk_demo),
        .reset        (reset),
        .tick         (tick),
        .btn_raw      (btn[1]),
        .level_toggle (rotate),
        .press        ()
    );

    button_conditioner u_btn_amt0 (
        .clk_demo     (clk_demo),
        .reset        (reset),
        .tick         (tick),
        .btn_raw      (btn[2]),
        .level_toggle (amt_lo[0]),
        .press        ()
    );

    button_conditioner u_btn_amt1 (
        .clk_demo     (clk_demo),
        .reset        (reset),
        .tick         (tick),
        .btn_raw      (btn[3]),
        .level_toggle (amt_lo[1]),
        .press        ()
    );

    // Press pulses step the high amount bits
    button_conditioner u_btn_adv (
        .clk_demo     (clk_demo),
        .reset        (reset),
        .tick         (tick),
        .btn_raw      (btn[4]),
        .level_toggle (),
        .press        (advance)
    );

    ////////////////////////////////////////
    // Control, shifter and display
    ////////////////////////////////////////
    shift_control u_shift_control (
        .clk_demo   (clk_demo),
        .reset      (reset),
        .sw         (sw),
        .dir        (dir),
        .rotate     (rotate),
        .amt_lo     (amt_lo),
        .advance    (advance),
        .ctrl       (u_shift_ctrl_if.ctrl),
        .result_out (result),
        .led        (led)
    );

    barrel_shifter u_barrel_shifter (
        .bus (u_shift_ctrl_if.shifter)
    );

    seg7_display u_seg7_display (
        .clk_demo (clk_demo),
        .reset    (reset),
        .tick     (tick),
        .value    (result),
        .seg      (seg),
        .an       (an)
    );

endmodule

`default_nettype wire

//--- testbench/tb_shifter_demo.sv
`default_nettype none
`include "shifter_defines.svh"

module tb_shifter_demo;
    import display_pkg::*;

    localparam int DW          = `SHIFT_DATA_W;
    localparam int TICK_CYCLES = `SHIFT_TICK_DIV;
    localparam int HOLD_TICKS  = 2 * (`SHIFT_DEBOUNCE_TICKS + 2);
    localparam int LED_LIMIT   = 4 * HOLD_TICKS * TICK_CYCLES;
    localparam int SCAN_LIMIT  = 24 * TICK_CYCLES;

    logic          clk_demo;
    logic          reset;
    logic [15:0]   sw;
    logic [4:0]    btn;
    logic [7:0]    led;
    logic [6:0]    seg;
    logic [7:0]    an;

    logic [31:0]   lfsr_state;
    int            mismatch_count;
    int            timeout_count;
    logic          exp_dir;
    logic          exp_rot;
    logic [1:0]    exp_lo;
    logic [1:0]    exp_hi;
    seg_t          captured [0:7];

    shifter_demo_top u_shifter_demo_top (
        .clk_demo (clk_demo),
        .reset    (reset),
        .sw       (sw),
        .btn      (btn),
        .led      (led),
        .seg      (seg),
        .an       (an)
    );

    always #5 clk_demo = ~clk_demo;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Standard hex digits, active low, a on bit 0
    function automatic seg_t expected_segments(input logic [3:0] hex);
        case (hex)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'ha:    return 7'b0001000;
            4'hb:    return 7'b0000011;
            4'hc:    return 7'b1000110;
            4'hd:    return 7'b0100001;
            4'he:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    // Bit i takes its value from the source bit amt places away
    function automatic logic [DW-1:0] model_shift(input logic [DW-1:0] data,
                                                 input logic [3:0] amt,
                                                 input logic rot,
                                                 input logic dir);
        logic [DW-1:0] r;
        int            a;
        int            src;
        a = int'(amt);
        for (int i = 0; i < DW; i++) begin
            src = dir ? i + a : i - a;
            if (src >= 0 && src < DW)
                r[i] = data[src];
            else if (rot)
                r[i] = data[(src + DW) % DW];
            else
                r[i] = 1'b0;
        end
        return r;
    endfunction

    function automatic logic [7:0] expected_led();
        return {exp_hi, exp_lo, exp_rot, exp_dir, 2'b00};
    endfunction

    ////////////////////////////////////////
    // Driver and monitor tasks
    ////////////////////////////////////////
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_demo);
        #1;
    endtask

    task automatic random_word(output logic [15:0] w);
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[14:0], lfsr_state[0]};
        end
    endtask

    task automatic press_button(input int idx);
        wait_cycles(1);
        btn[idx] = 1'b1;
        wait_cycles(HOLD_TICKS * TICK_CYCLES);
        btn[idx] = 1'b0;
        wait_cycles(HOLD_TICKS * TICK_CYCLES);
    endtask

    task automatic wait_led(input logic [7:0] expected);
        int n;
        n = 0;
        @(negedge clk_demo);
        while (led !== expected && n < LED_LIMIT) begin
            @(negedge clk_demo);
            n++;
        end
        if (led !== expected) begin
            $display("Timeout at %0t: led stayed at %h instead of reaching %h",
                     $time, led, expected);
            timeout_count++;
        end
    endtask

    // Press a button and follow the effect in the model
    task automatic operate_button(input int idx);
        press_button(idx);
        case (idx)
            0:       exp_dir   = ~exp_dir;
            1:       exp_rot   = ~exp_rot;
            2:       exp_lo[0] = ~exp_lo[0];
            3:       exp_lo[1] = ~exp_lo[1];
            default: exp_hi    = exp_hi + 2'd1;
        endcase
        wait_led(expected_led());
    endtask

    // Each position is captured on a fresh load of its anode
    task automatic read_display();
        logic [7:0] target;
        int         n;
        for (int p = 0; p < 8; p++) begin
            target = ~(8'b0000_0001 << p);
            n = 0;
            @(negedge clk_demo);
            while (an === target && n < SCAN_LIMIT) begin
                @(negedge clk_demo);
                n++;
            end
            while (an !== target && n < SCAN_LIMIT) begin
                @(negedge clk_demo);
                n++;
            end
            if (an !== target) begin
                $display("Timeout at %0t: digit %0d was never selected", $time, p);
                timeout_count++;
            end
            captured[p] = seg;
        end
    endtask

    task automatic check_display(input logic [15:0] word);
        seg_t want;
        read_display();
        for (int p = 0; p < 8; p++) begin
            want = (p < 4) ? expected_segments(word[4*p +: 4]) : SEG_BLANK;
            if (captured[p] !== want) begin
                $display("Mismatch at %0t: digit %0d seg = %b, expected %b (word %h)",
                         $time, p, captured[p], want, word);
                mismatch_count++;
            end
        end
    endtask

    task automatic set_op(input logic rot, input logic dir);
        if (exp_dir != dir)
            operate_button(0);
        if (exp_rot != rot)
            operate_button(1);
        if (led[3:2] !== {rot, dir}) begin
            $display("Mismatch at %0t: led[3:2] = %b, expected %b", $time, led[3:2],
                     {rot, dir});
            mismatch_count++;
        end
    endtask

    task automatic set_amount(input logic [3:0] amt);
        if (exp_lo[0] != amt[0])
            operate_button(2);
        if (exp_lo[1] != amt[1])
            operate_button(3);
        while (exp_hi != amt[3:2])
            operate_button(4);
        if (led[7:4] !== amt) begin
            $display("Mismatch at %0t: led[7:4] = %h, expected %h", $time, led[7:4], amt);
            mismatch_count++;
        end
    endtask

    task automatic apply_word(input logic [15:0] w);
        wait_cycles(1);
        sw = w;
        // Data register then a scan load
        wait_cycles(2);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic test_reset();
        int n;
        n = 0;
        @(negedge clk_demo);
        if (led !== 8'h00 || an !== 8'hff) begin
            $display("Mismatch at %0t: after reset led = %h an = %h", $time, led, an);
            mismatch_count++;
        end
        while (an === 8'hff && n < SCAN_LIMIT) begin
            @(negedge clk_demo);
            n++;
        end
        if (an === 8'hff) begin
            $display("Timeout at %0t: display scanning never started", $time);
            timeout_count++;
        end
    endtask

    task automatic test_passthrough();
        logic [15:0] w;
        for (int k = 0; k < 4; k++) begin
            random_word(w);
            apply_word(w);
            check_display(w);
        end
    endtask

    task automatic test_amount();
        logic [1:0] start_hi;
        set_amount(4'h3);
        set_amount(4'h6);
        start_hi = exp_hi;
        // Four presses bring the high pair around
        repeat (4) operate_button(4);
        if (led[7:6] !== start_hi) begin
            $display("Mismatch at %0t: led[7:6] = %b after four presses, expected %b",
                     $time, led[7:6], start_hi);
            mismatch_count++;
        end
    endtask

    task automatic test_operations();
        logic [15:0] w;
        logic [3:0]  amt;
        for (int op = 0; op < 4; op++) begin
            set_op(op[1], op[0]);
            for (int k = 0; k < 5; k++) begin
                case (k)
                    0:       amt = 4'd0;
                    1:       amt = 4'd1;
                    2:       amt = 4'd8;
                    3:       amt = 4'd15;
                    default: amt = 4'd6;
                endcase
                set_amount(amt);
                random_word(w);
                apply_word(w);
                check_display(model_shift(w, amt, exp_rot, exp_dir));
            end
        end
    endtask

    // Too short to pass the debounce filter
    task automatic test_short_pulse();
        wait_cycles(1);
        btn[0] = 1'b1;
        btn[4] = 1'b1;
        wait_cycles((`SHIFT_DEBOUNCE_TICKS - 1) * TICK_CYCLES);
        btn[0] = 1'b0;
        btn[4] = 1'b0;
        wait_cycles(HOLD_TICKS * TICK_CYCLES);
        if (led !== expected_led()) begin
            $display("Mismatch at %0t: led = %h after short pulse, expected %h",
                     $time, led, expected_led());
            mismatch_count++;
        end
    endtask

    initial begin
        clk_demo       = 1'b0;
        reset          = 1'b1;
        sw             = 16'h0000;
        btn            = 5'b00000;
        lfsr_state     = 32'hfd7a3e5e;
        mismatch_count = 0;
        timeout_count  = 0;
        exp_dir        = 1'b0;
        exp_rot        = 1'b0;
        exp_lo         = 2'b00;
        exp_hi         = 2'b00;
        wait_cycles(4);
        reset = 1'b0;

        test_reset();
        test_passthrough();
        test_amount();
        test_operations();
        test_short_pulse();

        $display("Done: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/shift_pkg.sv
common/display_pkg.sv
common/shift_ctrl_if.sv
hdl/tick_gen.sv
hdl/button_conditioner.sv
hdl/shift_control.sv
shifter/barrel_shifter.sv
display/seg7_display.sv
hdl/shifter_demo_top.sv
testbench/tb_shifter_demo.sv

//--- Bender.yml
package:
  name: shifter_demo

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/shift_pkg.sv
      - common/display_pkg.sv
      - common/shift_ctrl_if.sv
      - hdl/tick_gen.sv
      - hdl/button_conditioner.sv
      - hdl/shift_control.sv
      - shifter/barrel_shifter.sv
      - display/seg7_display.sv
      - hdl/shifter_demo_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_shifter_demo.sv
